// File: process_engine.f
verilog/hash_pkg.sv
verilog/bucket_if.sv
verilog/request_stage.sv
verilog/bucket_arbiter.sv
verilog/bucket_ram.sv
verilog/context_delay.sv
verilog/slot_matcher.sv
verilog/update_writer.sv
verilog/process_engine.sv
testbench/process_engine_checker.sv
testbench/process_engine_properties.sv
testbench/tb_process_engine.sv

// File: testbench/tb_process_engine.sv
// testbench top with clock, reset, directed and random stimulus and a reference model
`timescale 1ns/1ps

module tb_process_engine import hash_pkg::*; ();

  localparam int INDEX_WIDTH  = 4;
  localparam int READ_LATENCY = 2;
  localparam int NUM_BUCKETS  = 2 ** INDEX_WIDTH;
  localparam int POOL_SIZE    = 24;
  localparam int STALL_LIMIT  = 200;
  localparam int DRAIN_LIMIT  = 500;

  logic                 clock;
  logic                 reset;
  logic                 input_valid;
  opcode_t              opcode;
  logic [KEY_WIDTH-1:0] key;
  logic [VAL_WIDTH-1:0] wr_data;
  logic                 stall;
  logic                 output_valid;
  logic [VAL_WIDTH-1:0] val_out;
  rescode_t             rescode;

  logic [KEY_WIDTH-1:0] model_key [NUM_BUCKETS*NUM_SLOTS];  // zero key is an empty slot
  logic [VAL_WIDTH-1:0] model_val [NUM_BUCKETS*NUM_SLOTS];
  bit                   timed_out;

  process_engine #(.INDEX_WIDTH(INDEX_WIDTH), .READ_LATENCY(READ_LATENCY)) u_dut (
    .clock(clock), .reset(reset), .input_valid(input_valid), .opcode(opcode),
    .key(key), .wr_data(wr_data), .stall(stall), .output_valid(output_valid),
    .val_out(val_out), .rescode(rescode)
  );

  process_engine_checker u_checker (
    .clock(clock), .reset(reset), .output_valid(output_valid),
    .val_out(val_out), .rescode(rescode)
  );

  always #10 clock = ~clock;

  // six keys per bucket for buckets 0 to 3
  function automatic logic [KEY_WIDTH-1:0] pool_key(input int i);
    logic [3:0] b;
    logic [3:0] j;
    b = 4'(i / 6);
    j = 4'(i % 6 + 1);
    return {4'h0, j, j, b};  // nibbles xor down to b
  endfunction

  function automatic int bucket_of(input logic [KEY_WIDTH-1:0] k);
    int h;
    h = 0;
    for (int i = 0; i < KEY_WIDTH; i += INDEX_WIDTH) begin
      h = h ^ int'((k >> i) & (NUM_BUCKETS - 1));
    end
    return h;
  endfunction

  task automatic apply_model(input opcode_t op, input logic [KEY_WIDTH-1:0] k,
                             input logic [VAL_WIDTH-1:0] d);
    int                   base;
    int                   hit;
    int                   free;
    rescode_t             code;
    logic [VAL_WIDTH-1:0] v;
    base = bucket_of(k) * NUM_SLOTS;
    hit  = -1;
    free = -1;
    for (int s = NUM_SLOTS - 1; s >= 0; s--) begin  // lowest slot wins
      if (model_key[base + s] == k) hit = s;
      if (model_key[base + s] == '0) free = s;
    end
    v    = '0;
    code = res_miss;
    case (op)
      op_search: begin
        if (hit >= 0) begin
          code = res_found;
          v    = model_val[base + hit];
        end
      end
      op_insert: begin
        if (hit >= 0) begin
          code = res_updated;
          model_val[base + hit] = d;
        end else if (free >= 0) begin
          code = res_inserted;
          model_key[base + free] = k;
          model_val[base + free] = d;
        end else begin
          code = res_full;
        end
      end
      op_delete: begin
        if (hit >= 0) begin
          code = res_deleted;
          model_key[base + hit] = '0;
          model_val[base + hit] = '0;
        end
      end
      default: ;
    endcase
    if (op != op_nop) u_checker.push_expected(code, v);
  endtask

  // called on a falling edge, returns on the falling edge after acceptance
  task automatic send_op(input opcode_t op, input logic [KEY_WIDTH-1:0] k,
                         input logic [VAL_WIDTH-1:0] d);
    int waited;
    if (timed_out) return;
    input_valid = 1'b1;
    opcode      = op;
    key         = k;
    wr_data     = d;
    waited      = 0;
    while (stall && waited < STALL_LIMIT) begin
      @(negedge clock);
      waited++;
    end
    if (stall) begin
      $display("timeout: stall stayed high for %0d cycles", STALL_LIMIT);
      timed_out   = 1'b1;
      input_valid = 1'b0;
    end else begin
      apply_model(op, k, d);  // accepted on the coming rising edge
      @(negedge clock);
    end
  endtask

  task automatic idle(input int cycles);
    input_valid = 1'b0;
    repeat (cycles) @(negedge clock);
  endtask

  task automatic drain();
    int waited;
    input_valid = 1'b0;
    waited      = 0;
    while (u_checker.outstanding() != 0 && waited < DRAIN_LIMIT) begin
      @(negedge clock);
      waited++;
    end
    if (u_checker.outstanding() != 0) begin
      $display("timeout: %0d results still missing after %0d cycles",
               u_checker.outstanding(), DRAIN_LIMIT);
      timed_out = 1'b1;
    end
    repeat (4) @(negedge clock);  // room for stray outputs
  endtask

  task automatic random_mix(input int count);
    int unsigned pick;
    opcode_t     op;
    for (int n = 0; n < count && !timed_out; n++) begin
      pick = $urandom_range(0, 9);
      if (pick == 0) op = op_nop;
      else if (pick <= 4) op = op_search;
      else if (pick <= 7) op = op_insert;
      else op = op_delete;
      send_op(op, pool_key($urandom_range(0, POOL_SIZE - 1)), VAL_WIDTH'($urandom));
      if ($urandom_range(0, 2) == 0) idle($urandom_range(1, 3));
    end
  endtask

  initial begin
    clock       = 1'b0;
    reset       = 1'b1;
    input_valid = 1'b0;
    opcode      = op_nop;
    key         = '0;
    wr_data     = '0;
    timed_out   = 1'b0;
    void'($urandom(32'h38a5));
    for (int i = 0; i < NUM_BUCKETS * NUM_SLOTS; i++) begin
      model_key[i] = '0;
      model_val[i] = '0;
    end
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    u_checker.start_test("empty_search");
    for (int i = 0; i < POOL_SIZE; i += 7) send_op(op_search, pool_key(i), '0);
    drain();
    u_checker.end_test();

    u_checker.start_test("insert_search");
    send_op(op_insert, pool_key(6), 16'h1234);
    send_op(op_search, pool_key(6), '0);
    send_op(op_insert, pool_key(6), 16'hbeef);
    send_op(op_search, pool_key(6), '0);
    drain();
    u_checker.end_test();

    u_checker.start_test("full_bucket");
    for (int i = 12; i < 17; i++) send_op(op_insert, pool_key(i), 16'(16'ha000 + i));
    send_op(op_search, pool_key(16), '0);
    for (int i = 12; i < 16; i++) send_op(op_search, pool_key(i), '0);
    drain();
    u_checker.end_test();

    u_checker.start_test("delete_reuse");
    send_op(op_delete, pool_key(13), '0);
    send_op(op_search, pool_key(13), '0);
    send_op(op_delete, pool_key(13), '0);
    send_op(op_insert, pool_key(17), 16'h5a5a);  // takes the freed slot
    send_op(op_search, pool_key(17), '0);
    send_op(op_insert, pool_key(16), 16'h0f0f);  // bucket full again
    drain();
    u_checker.end_test();

    u_checker.start_test("random_mix");
    random_mix(400);
    drain();
    u_checker.end_test();

    u_checker.report_totals();
    if (timed_out || u_checker.error_total() != 0) begin
      $display("Simulation FAILED");
    end else begin
      $display("Simulation PASSED");
    end
    $finish;
  end

endmodule

// File: testbench/process_engine_properties.sv
// concurrent assertions on reset, result codes, grants and output latency
`timescale 1ns/1ps

module process_engine_properties import hash_pkg::*; #(
  parameter int OUTPUT_BOUND = 64  // worst case incl. reset sweep and hazards
) (
  input logic     clock,
  input logic     reset,
  input logic     input_valid,
  input opcode_t  opcode,
  input logic     stall,
  input logic     output_valid,
  input rescode_t rescode,
  input logic     lookup_grant,
  input logic     update_grant,
  input logic     ram_req,
  input logic     ram_grant,
  input logic     ram_write
);

  quiet_after_reset: assert property (@(posedge clock) reset |=> (!stall && !output_valid))
    else $error("stall or output_valid high after a reset cycle");

  legal_rescode: assert property (@(posedge clock) disable iff (reset)
    output_valid |-> (rescode inside {res_miss, res_found, res_inserted, res_updated,
                                      res_full, res_deleted}))
    else $error("illegal result code on the output");

  // each memory access belongs to one port, writes to the update side
  single_grant: assert property (@(posedge clock) disable iff (reset)
    (ram_req && ram_grant) |-> (ram_write ? (update_grant && !lookup_grant)
                                          : (lookup_grant && !update_grant)))
    else $error("bucket memory access not owned by exactly one port");

  output_follows: assert property (@(posedge clock) disable iff (reset)
    (input_valid && !stall && (opcode != op_nop)) |-> ##[1:OUTPUT_BOUND] output_valid)
    else $error("accepted operation without a result in time");

endmodule

bind process_engine process_engine_properties u_properties (
  .clock(clock), .reset(reset), .input_valid(input_valid), .opcode(opcode),
  .stall(stall), .output_valid(output_valid), .rescode(rescode),
  .lookup_grant(lookup_port.grant), .update_grant(update_port.grant),
  .ram_req(ram_port.req), .ram_grant(ram_port.grant), .ram_write(ram_port.write)
);

// File: testbench/process_engine_checker.sv
// result checker with expected queues, per-test counters and summary lines
`timescale 1ns/1ps

module process_engine_checker import hash_pkg::*; (
  input logic                 clock,
  input logic                 reset,
  input logic                 output_valid,
  input logic [VAL_WIDTH-1:0] val_out,
  input rescode_t             rescode
);

  logic [2:0]           exp_code_q [$];
  logic [VAL_WIDTH-1:0] exp_val_q [$];
  logic [2:0]           exp_code;
  logic [VAL_WIDTH-1:0] exp_val;
  string                test_name    = "none";
  int                   test_checks  = 0;
  int                   test_errors  = 0;
  int                   total_checks = 0;
  int                   total_errors = 0;
  int                   total_tests  = 0;

  function automatic string code_name(input logic [2:0] c);
    case (c)
      3'd0:    return "miss";
      3'd1:    return "found";
      3'd2:    return "inserted";
      3'd3:    return "updated";
      3'd4:    return "full";
      3'd5:    return "deleted";
      default: return "illegal";
    endcase
  endfunction

  task automatic push_expected(input rescode_t c, input logic [VAL_WIDTH-1:0] v);
    exp_code_q.push_back(c);
    exp_val_q.push_back(v);
  endtask

  function automatic int outstanding();
    return exp_code_q.size();
  endfunction

  function automatic int error_total();
    return total_errors + test_errors;
  endfunction

  task automatic start_test(input string name);
    test_name   = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic end_test();
    $display("test %-14s %0d checks, %0d errors", test_name, test_checks, test_errors);
    total_checks += test_checks;
    total_errors += test_errors;
    total_tests++;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic report_totals();
    $display("%0d tests, %0d checks, %0d errors", total_tests, total_checks, error_total());
  endtask

  // outputs are registered, so the values seen here are those of the past cycle
  always @(posedge clock) begin
    if (!reset && output_valid) begin
      if (exp_code_q.size() == 0) begin
        $display("test %s got a result while no operation was outstanding", test_name);
        test_errors++;
      end else begin
        exp_code = exp_code_q.pop_front();
        exp_val  = exp_val_q.pop_front();
        test_checks++;
        if ((rescode !== exp_code) || (val_out !== exp_val)) begin
          $display("[ERROR] %s expected %s val %h, actual %s val %h", test_name,
                   code_name(exp_code), exp_val, code_name(rescode), val_out);
          test_errors++;
        end
      end
    end
  end

endmodule

// File: verilog/process_engine.sv
// hash table process engine top, lookup and update paths around one bucket memory
`timescale 1ns/1ps

module process_engine #(
  parameter int INDEX_WIDTH  = 4,
  parameter int READ_LATENCY = 2
) (
  input  logic                           clock,
  input  logic                           reset,
  input  logic                           input_valid,
  input  hash_pkg::opcode_t              opcode,
  input  logic [hash_pkg::KEY_WIDTH-1:0] key,
  input  logic [hash_pkg::VAL_WIDTH-1:0] wr_data,
  output logic                           stall,
  output logic                           output_valid,
  output logic [hash_pkg::VAL_WIDTH-1:0] val_out,
  output hash_pkg::rescode_t             rescode
);

  bucket_if #(.INDEX_WIDTH(INDEX_WIDTH)) lookup_port ();
  bucket_if #(.INDEX_WIDTH(INDEX_WIDTH)) update_port ();
  bucket_if #(.INDEX_WIDTH(INDEX_WIDTH)) ram_port ();

  logic                                issue_valid;
  hash_pkg::op_ctx_t                   issue_ctx;
  logic                                read_valid;
  hash_pkg::op_ctx_t                   read_ctx;
  logic                                match_valid;
  hash_pkg::op_ctx_t                   match_ctx;
  hash_pkg::rescode_t                  match_rescode;
  logic [hash_pkg::VAL_WIDTH-1:0]      match_val;
  logic [hash_pkg::SLOT_SEL_WIDTH-1:0] hit_slot;
  logic [hash_pkg::SLOT_SEL_WIDTH-1:0] free_slot;
  logic                                update_done;
  hash_pkg::result_t                   match_result;
  hash_pkg::result_t                   final_result;

  assign match_result = '{rescode: match_rescode, val: match_val};
  assign rescode      = final_result.rescode;
  assign val_out      = final_result.val;

  request_stage #(.INDEX_WIDTH(INDEX_WIDTH)) u_request_stage (
    .clock(clock), .reset(reset), .input_valid(input_valid), .opcode(opcode),
    .key(key), .wr_data(wr_data), .update_done(update_done), .stall(stall),
    .lookup_port(lookup_port.requester), .issue_valid(issue_valid), .issue_ctx(issue_ctx)
  );

  bucket_arbiter u_bucket_arbiter (
    .lookup_port(lookup_port.memory), .update_port(update_port.memory),
    .ram_port(ram_port.requester)
  );

  bucket_ram #(.INDEX_WIDTH(INDEX_WIDTH), .READ_LATENCY(READ_LATENCY)) u_bucket_ram (
    .clock(clock), .reset(reset), .ram_port(ram_port.memory)
  );

  // context rides beside the memory read
  context_delay #(.payload_t(hash_pkg::op_ctx_t), .DEPTH(READ_LATENCY)) u_read_delay (
    .clock(clock), .reset(reset), .in_valid(issue_valid), .in_data(issue_ctx),
    .out_valid(read_valid), .out_data(read_ctx)
  );

  slot_matcher u_slot_matcher (
    .clock(clock), .reset(reset), .in_valid(read_valid), .ctx(read_ctx),
    .line(lookup_port.rd_line), .out_valid(match_valid), .out_ctx(match_ctx),
    .rescode(match_rescode), .val_out(match_val), .hit_slot(hit_slot),
    .free_slot(free_slot), .free_found(), .line_out()
  );

  update_writer #(.INDEX_WIDTH(INDEX_WIDTH)) u_update_writer (
    .clock(clock), .reset(reset), .in_valid(match_valid), .ctx(match_ctx),
    .rescode(match_rescode), .hit_slot(hit_slot), .free_slot(free_slot),
    .update_port(update_port.requester), .update_done(update_done)
  );

  // results leave alongside the write request
  context_delay #(.payload_t(hash_pkg::result_t), .DEPTH(1)) u_output_delay (
    .clock(clock), .reset(reset), .in_valid(match_valid), .in_data(match_result),
    .out_valid(output_valid), .out_data(final_result)
  );

endmodule

// File: verilog/update_writer.sv
// insert and delete write builder with slot enables and update completion
`timescale 1ns/1ps

module update_writer import hash_pkg::*; #(
  parameter int INDEX_WIDTH = 4
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      in_valid,
  input  op_ctx_t                   ctx,
  input  rescode_t                  rescode,
  input  logic [SLOT_SEL_WIDTH-1:0] hit_slot,
  input  logic [SLOT_SEL_WIDTH-1:0] free_slot,
  bucket_if.requester               update_port,
  output logic                      update_done
);

  logic                      wr_pending;
  logic                      done_only;
  logic [INDEX_WIDTH-1:0]    wr_index;
  line_t                     wr_line;
  logic [NUM_SLOTS-1:0]      wr_we;
  logic                      writes;
  logic                      is_update;
  logic                      granted;
  logic [SLOT_SEL_WIDTH-1:0] target;
  slot_t                     new_slot;

  assign is_update = (ctx.opcode == op_insert) || (ctx.opcode == op_delete);
  assign writes    = in_valid && (rescode inside {res_inserted, res_updated, res_deleted});
  assign target    = (rescode == res_inserted) ? free_slot : hit_slot;

  always_comb begin
    new_slot = '0;  // delete clears the slot
    if (rescode != res_deleted) begin
      new_slot.key = ctx.key;
      new_slot.val = ctx.wr_data;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_pending <= 1'b0;
      done_only  <= 1'b0;
    end else begin
      if (writes) begin
        wr_pending <= 1'b1;
      end else if (granted) begin
        wr_pending <= 1'b0;
      end
      done_only <= in_valid && is_update && !writes;  // full or miss, nothing to write
    end
  end

  always_ff @(posedge clock) begin
    if (writes) begin
      wr_index        <= ctx.index[INDEX_WIDTH-1:0];
      wr_line         <= {NUM_SLOTS{new_slot}};  // enables pick the slot
      wr_we           <= '0;
      wr_we[target]   <= 1'b1;
    end
  end

  assign update_port.req     = wr_pending;
  assign update_port.write   = 1'b1;
  assign update_port.index   = wr_index;
  assign update_port.wr_line = wr_line;
  assign update_port.slot_we = wr_we;

  assign granted     = update_port.req && update_port.grant;
  assign update_done = granted || done_only;

endmodule

// File: verilog/slot_matcher.sv
// slot key compare, lowest hit and free slot search, result code
`timescale 1ns/1ps

module slot_matcher import hash_pkg::*; (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      in_valid,
  input  op_ctx_t                   ctx,
  input  line_t                     line,
  output logic                      out_valid,
  output op_ctx_t                   out_ctx,
  output rescode_t                  rescode,
  output logic [VAL_WIDTH-1:0]      val_out,
  output logic [SLOT_SEL_WIDTH-1:0] hit_slot,
  output logic [SLOT_SEL_WIDTH-1:0] free_slot,
  output logic                      free_found,
  output line_t                     line_out
);

  logic [SLOT_SEL_WIDTH-1:0] hit_idx;
  logic [SLOT_SEL_WIDTH-1:0] free_idx;
  logic                      any_hit;
  logic                      any_free;
  rescode_t                  code;

  // scan from the top so the lowest slot wins
  always_comb begin
    hit_idx  = '0;
    free_idx = '0;
    any_hit  = 1'b0;
    any_free = 1'b0;
    for (int s = NUM_SLOTS - 1; s >= 0; s--) begin
      if ((line[s].key == ctx.key) && (ctx.key != '0)) begin
        hit_idx = SLOT_SEL_WIDTH'(s);
        any_hit = 1'b1;
      end
      if (line[s].key == '0) begin  // zero key marks an empty slot
        free_idx = SLOT_SEL_WIDTH'(s);
        any_free = 1'b1;
      end
    end
  end

  always_comb begin
    case (ctx.opcode)
      op_search: code = any_hit ? res_found : res_miss;
      op_insert: code = any_hit ? res_updated : (any_free ? res_inserted : res_full);
      op_delete: code = any_hit ? res_deleted : res_miss;
      default:   code = res_miss;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clock) begin
    out_ctx    <= ctx;
    rescode    <= code;
    val_out    <= (code == res_found) ? line[hit_idx].val : '0;  // value only on a search hit
    hit_slot   <= hit_idx;
    free_slot  <= free_idx;
    free_found <= any_free;
    line_out   <= line;
  end

endmodule

// File: verilog/context_delay.sv
// valid-qualified shift register for any payload type
`timescale 1ns/1ps

module context_delay #(
  parameter type payload_t = logic,
  parameter int  DEPTH     = 1
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  logic [DEPTH-1:0] valid_sr;
  payload_t         data_sr [DEPTH];

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_sr <= '0;
    end else begin
      valid_sr[0] <= in_valid;
      for (int i = 1; i < DEPTH; i++) begin
        valid_sr[i] <= valid_sr[i-1];
      end
    end
  end

  always_ff @(posedge clock) begin
    data_sr[0] <= in_data;
    for (int i = 1; i < DEPTH; i++) begin
      data_sr[i] <= data_sr[i-1];
    end
  end

  assign out_valid = valid_sr[DEPTH-1];
  assign out_data  = data_sr[DEPTH-1];

endmodule

// File: verilog/bucket_ram.sv
// bucket line memory with per-slot write enables, reset sweep and read pipeline
`timescale 1ns/1ps

module bucket_ram import hash_pkg::*; #(
  parameter int INDEX_WIDTH  = 4,
  parameter int READ_LATENCY = 2
) (
  input  logic     clock,
  input  logic     reset,
  bucket_if.memory ram_port
);

  localparam int NUM_LINES = 2 ** INDEX_WIDTH;

  logic [LINE_WIDTH-1:0]  mem [NUM_LINES];
  line_t                  rd_pipe [READ_LATENCY];
  line_t                  cur_line;
  line_t                  merged_line;
  logic                   sweeping;
  logic [INDEX_WIDTH-1:0] sweep_index;
  logic                   access;

  assign ram_port.grant = ram_port.req && !sweeping;
  assign access         = ram_port.req && ram_port.grant;
  assign cur_line       = mem[ram_port.index];

  // keep the slots whose enable is low
  always_comb begin
    merged_line = cur_line;
    for (int s = 0; s < NUM_SLOTS; s++) begin
      if (ram_port.slot_we[s]) begin
        merged_line[s] = ram_port.wr_line[s];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      sweeping    <= 1'b1;
      sweep_index <= '0;
    end else if (sweeping) begin
      sweep_index <= sweep_index + 1'b1;
      if (&sweep_index) begin
        sweeping <= 1'b0;  // last line cleared
      end
    end
  end

  always_ff @(posedge clock) begin
    if (sweeping) begin
      mem[sweep_index] <= '0;
    end else if (access && ram_port.write) begin
      mem[ram_port.index] <= merged_line;
    end
    rd_pipe[0] <= cur_line;
    for (int i = 1; i < READ_LATENCY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign ram_port.rd_line = rd_pipe[READ_LATENCY-1];  // READ_LATENCY cycles after grant

endmodule

// File: verilog/bucket_arbiter.sv
// fixed priority arbiter for the bucket memory, update writes ahead of lookup reads
`timescale 1ns/1ps

module bucket_arbiter (
  bucket_if.memory    lookup_port,
  bucket_if.memory    update_port,
  bucket_if.requester ram_port
);

  logic pick_update;

  assign pick_update = update_port.req;

  assign ram_port.req     = lookup_port.req || update_port.req;
  assign ram_port.write   = pick_update ? update_port.write   : lookup_port.write;
  assign ram_port.index   = pick_update ? update_port.index   : lookup_port.index;
  assign ram_port.wr_line = pick_update ? update_port.wr_line : lookup_port.wr_line;
  assign ram_port.slot_we = pick_update ? update_port.slot_we : lookup_port.slot_we;

  // lookup only gets the memory when no write is waiting
  assign update_port.grant = update_port.req && ram_port.grant;
  assign lookup_port.grant = lookup_port.req && !update_port.req && ram_port.grant;

  assign lookup_port.rd_line = ram_port.rd_line;
  assign update_port.rd_line = ram_port.rd_line;  // unused by the writer

endmodule

// File: verilog/request_stage.sv
// operation intake, folding hash, bucket read request, pending update tracking and stall
`timescale 1ns/1ps

module request_stage import hash_pkg::*; #(
  parameter int INDEX_WIDTH = 4
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 input_valid,
  input  opcode_t              opcode,
  input  logic [KEY_WIDTH-1:0] key,
  input  logic [VAL_WIDTH-1:0] wr_data,
  input  logic                 update_done,
  output logic                 stall,
  bucket_if.requester          lookup_port,
  output logic                 issue_valid,
  output op_ctx_t              issue_ctx
);

  localparam int NUM_CHUNKS = (KEY_WIDTH + INDEX_WIDTH - 1) / INDEX_WIDTH;

  logic                   hold_valid;
  op_ctx_t                hold_ctx;
  logic                   hold_is_update;
  logic                   pending;
  logic [INDEX_WIDTH-1:0] pending_index;
  logic                   hazard;
  logic                   granted;
  logic                   accept;

  // xor of all INDEX_WIDTH-bit chunks of the key, top chunk zero padded
  function automatic logic [INDEX_WIDTH-1:0] fold_hash(input logic [KEY_WIDTH-1:0] k);
    logic [NUM_CHUNKS*INDEX_WIDTH-1:0] padded;
    logic [INDEX_WIDTH-1:0]            h;
    padded = '0;
    padded[KEY_WIDTH-1:0] = k;
    h = '0;
    for (int i = 0; i < NUM_CHUNKS; i++) begin
      h ^= padded[i*INDEX_WIDTH +: INDEX_WIDTH];
    end
    return h;
  endfunction

  assign hold_is_update = (hold_ctx.opcode == op_insert) || (hold_ctx.opcode == op_delete);

  // same bucket as the update in flight, or a second update
  assign hazard = pending &&
                  ((hold_ctx.index[INDEX_WIDTH-1:0] == pending_index) || hold_is_update);

  assign lookup_port.req     = hold_valid && !hazard;
  assign lookup_port.write   = 1'b0;  // read only
  assign lookup_port.index   = hold_ctx.index[INDEX_WIDTH-1:0];
  assign lookup_port.wr_line = '0;
  assign lookup_port.slot_we = '0;

  assign granted     = lookup_port.req && lookup_port.grant;
  assign stall       = hold_valid && !granted;
  assign accept      = input_valid && !stall;
  assign issue_valid = granted;
  assign issue_ctx   = hold_ctx;

  always_ff @(posedge clock) begin
    if (reset) begin
      hold_valid <= 1'b0;
      pending    <= 1'b0;
    end else begin
      if (accept) begin
        hold_valid <= (opcode != op_nop);  // nops drop out here
      end else if (granted) begin
        hold_valid <= 1'b0;
      end
      if (granted && hold_is_update) begin
        pending <= 1'b1;
      end else if (update_done) begin
        pending <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      hold_ctx <= '{opcode:  opcode,
                    key:     key,
                    wr_data: wr_data,
                    index:   MAX_INDEX_WIDTH'(fold_hash(key))};
    end
    if (granted && hold_is_update) begin
      pending_index <= hold_ctx.index[INDEX_WIDTH-1:0];
    end
  end

endmodule

// File: verilog/bucket_if.sv
// bucket memory access port with requester and memory modports
`timescale 1ns/1ps

interface bucket_if #(
  parameter int INDEX_WIDTH = 4
);

  logic                           req;
  logic                           write;    // low for a read
  logic                           grant;
  logic [INDEX_WIDTH-1:0]         index;
  hash_pkg::line_t                wr_line;
  logic [hash_pkg::NUM_SLOTS-1:0] slot_we;  // one bit per slot
  hash_pkg::line_t                rd_line;

  // access takes place when req and grant are both high
  modport requester (
    output req,
    output write,
    output index,
    output wr_line,
    output slot_we,
    input  grant,
    input  rd_line
  );

  modport memory (
    input  req,
    input  write,
    input  index,
    input  wr_line,
    input  slot_we,
    output grant,
    output rd_line
  );

endinterface

// File: verilog/hash_pkg.sv
// opcode and result enums, key/value widths, slot, line, context and result types
package hash_pkg;

  typedef enum logic [1:0] {
    op_nop,
    op_search,
    op_insert,
    op_delete
  } opcode_t;

  typedef enum logic [2:0] {
    res_miss,      // search or delete without a match
    res_found,
    res_inserted,  // insert took an empty slot
    res_updated,   // insert overwrote a matching slot
    res_full,
    res_deleted
  } rescode_t;

  localparam int KEY_WIDTH       = 16;
  localparam int VAL_WIDTH       = 16;
  localparam int NUM_SLOTS       = 4;
  localparam int SLOT_WIDTH      = KEY_WIDTH + VAL_WIDTH;
  localparam int LINE_WIDTH      = NUM_SLOTS * SLOT_WIDTH;
  localparam int SLOT_SEL_WIDTH  = $clog2(NUM_SLOTS);
  localparam int MAX_INDEX_WIDTH = 8;

  // key in the low bits of each slot
  typedef struct packed {
    logic [VAL_WIDTH-1:0] val;
    logic [KEY_WIDTH-1:0] key;
  } slot_t;

  typedef slot_t [NUM_SLOTS-1:0] line_t;  // slot 0 lowest

  typedef struct packed {
    opcode_t                    opcode;
    logic [KEY_WIDTH-1:0]       key;
    logic [VAL_WIDTH-1:0]       wr_data;
    logic [MAX_INDEX_WIDTH-1:0] index;  // upper bits zero
  } op_ctx_t;

  typedef struct packed {
    rescode_t             rescode;
    logic [VAL_WIDTH-1:0] val;
  } result_t;

endpackage
